// File: design/llc_mshr_pkg.sv
`default_nettype none

package llc_mshr_pkg;

    // table size
    localparam int N_MSHR = 4;
    // index into the table
    localparam int MSHR_BITS = 2;

    // address breakdown widths
    localparam int TAG_BITS = 16;
    localparam int SET_BITS = 8;
    localparam int WAY_BITS = 4;

    // per-entry bookkeeping widths
    localparam int STATE_BITS = 3;
    localparam int INVACK_BITS = 4;
    localparam int MSG_BITS = 5;
    localparam int REQ_ID_BITS = 4;
    localparam int HPROT_BITS = 2;

    // line geometry, one mask bit per word
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS = 32;
    localparam int LINE_BITS = WORDS_PER_LINE * WORD_BITS;

    // unstable-state code of a free entry
    // reset leaves every entry here
    localparam logic [STATE_BITS-1:0] LLC_I = 3'd0;

    // op codes from the controller FSM
    localparam int OP_BITS = 3;
    // nothing to do, index and hit hold
    localparam logic [OP_BITS-1:0] OP_IDLE = 3'd0;
    // hit search on tag and set
    localparam logic [OP_BITS-1:0] OP_LOOKUP = 3'd1;
    // free-entry search plus set-conflict triggers
    localparam logic [OP_BITS-1:0] OP_PEEK_REQ = 3'd2;

endpackage

`default_nettype wire

// File: design/mshr_write_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mshr_write_if;

    // full entry write at the current index
    logic add_entry;

    // single-field rewrites of the current entry
    logic upd_tag;
    logic upd_state;
    logic upd_line;
    logic upd_word_mask;
    logic upd_invack_cnt;

    // values written on add or on the matching upd_ strobe
    logic [llc_mshr_pkg::MSG_BITS-1:0] msg;
    logic [llc_mshr_pkg::REQ_ID_BITS-1:0] req_id;
    logic [llc_mshr_pkg::TAG_BITS-1:0] tag;
    logic [llc_mshr_pkg::WAY_BITS-1:0] way;
    logic [llc_mshr_pkg::STATE_BITS-1:0] state;
    logic [llc_mshr_pkg::HPROT_BITS-1:0] hprot;
    logic [llc_mshr_pkg::INVACK_BITS-1:0] invack_cnt;
    logic [llc_mshr_pkg::LINE_BITS-1:0] line;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_reg;
    // set of the incoming request address
    logic [llc_mshr_pkg::SET_BITS-1:0] set;

    // controller side drives strobes and values
    modport ctrl (
        output add_entry, upd_tag, upd_state, upd_line, upd_word_mask, upd_invack_cnt,
        output msg, req_id, tag, way, state, hprot, invack_cnt, line,
        output word_mask, word_mask_reg, set
    );

    // entry storage side, all inputs
    modport tbl (
        input add_entry, upd_tag, upd_state, upd_line, upd_word_mask, upd_invack_cnt,
        input msg, req_id, tag, way, state, hprot, invack_cnt, line,
        input word_mask, word_mask_reg, set
    );

endinterface

`default_nettype wire

// File: design/mshr_entry_table.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_table (
    input  logic clk,
    input  logic rst,
    mshr_write_if.tbl wr_if,
    input  logic [llc_mshr_pkg::MSHR_BITS-1:0] mshr_idx_i,
    // per-entry fields for the search
    output logic [llc_mshr_pkg::TAG_BITS-1:0] tags_o [llc_mshr_pkg::N_MSHR],
    output logic [llc_mshr_pkg::SET_BITS-1:0] sets_o [llc_mshr_pkg::N_MSHR],
    output logic [llc_mshr_pkg::STATE_BITS-1:0] states_o [llc_mshr_pkg::N_MSHR],
    // entry at the registered index
    output logic [llc_mshr_pkg::MSG_BITS-1:0] cur_msg_o,
    output logic [llc_mshr_pkg::REQ_ID_BITS-1:0] cur_req_id_o,
    output logic [llc_mshr_pkg::TAG_BITS-1:0] cur_tag_o,
    output logic [llc_mshr_pkg::SET_BITS-1:0] cur_set_o,
    output logic [llc_mshr_pkg::WAY_BITS-1:0] cur_way_o,
    output logic [llc_mshr_pkg::STATE_BITS-1:0] cur_state_o,
    output logic [llc_mshr_pkg::HPROT_BITS-1:0] cur_hprot_o,
    output logic [llc_mshr_pkg::INVACK_BITS-1:0] cur_invack_cnt_o,
    output logic [llc_mshr_pkg::LINE_BITS-1:0] cur_line_o,
    output logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_o,
    output logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_reg_o
);

    // entry storage, one slot per field
    logic [llc_mshr_pkg::MSG_BITS-1:0] msg_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::REQ_ID_BITS-1:0] req_id_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::TAG_BITS-1:0] tag_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::SET_BITS-1:0] set_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::WAY_BITS-1:0] way_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::STATE_BITS-1:0] state_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::HPROT_BITS-1:0] hprot_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::INVACK_BITS-1:0] invack_cnt_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::LINE_BITS-1:0] line_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_q [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_reg_q [llc_mshr_pkg::N_MSHR];

    // one-hot select of the entry at the registered index
    logic [llc_mshr_pkg::N_MSHR-1:0] wr_sel;

    always_comb begin
        for (int unsigned k = 0; k < llc_mshr_pkg::N_MSHR; k++) begin
            wr_sel[k] = (mshr_idx_i == k[llc_mshr_pkg::MSHR_BITS-1:0]);
        end
    end

    for (genvar i = 0; i < llc_mshr_pkg::N_MSHR; i++) begin : g_entry
        // fields written only on add
        // set comes from the request address
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                msg_q[i] <= '0;
                req_id_q[i] <= '0;
                set_q[i] <= '0;
                way_q[i] <= '0;
                hprot_q[i] <= '0;
                word_mask_reg_q[i] <= '0;
            end else if (wr_if.add_entry && wr_sel[i]) begin
                msg_q[i] <= wr_if.msg;
                req_id_q[i] <= wr_if.req_id;
                set_q[i] <= wr_if.set;
                way_q[i] <= wr_if.way;
                hprot_q[i] <= wr_if.hprot;
                word_mask_reg_q[i] <= wr_if.word_mask_reg;
            end
        end

        // state, LLC_I here frees the entry
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state_q[i] <= llc_mshr_pkg::LLC_I;
            end else if ((wr_if.add_entry || wr_if.upd_state) && wr_sel[i]) begin
                state_q[i] <= wr_if.state;
            end
        end

        // line data
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                line_q[i] <= '0;
            end else if ((wr_if.add_entry || wr_if.upd_line) && wr_sel[i]) begin
                line_q[i] <= wr_if.line;
            end
        end

        // tag
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                tag_q[i] <= '0;
            end else if ((wr_if.add_entry || wr_if.upd_tag) && wr_sel[i]) begin
                tag_q[i] <= wr_if.tag;
            end
        end

        // word mask
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                word_mask_q[i] <= '0;
            end else if ((wr_if.add_entry || wr_if.upd_word_mask) && wr_sel[i]) begin
                word_mask_q[i] <= wr_if.word_mask;
            end
        end

        // pending invalidation acks
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                invack_cnt_q[i] <= '0;
            end else if ((wr_if.add_entry || wr_if.upd_invack_cnt) && wr_sel[i]) begin
                invack_cnt_q[i] <= wr_if.invack_cnt;
            end
        end
    end

    // search sees every entry
    assign tags_o = tag_q;
    assign sets_o = set_q;
    assign states_o = state_q;

    // current-entry view, mux on the registered index
    assign cur_msg_o = msg_q[mshr_idx_i];
    assign cur_req_id_o = req_id_q[mshr_idx_i];
    assign cur_tag_o = tag_q[mshr_idx_i];
    assign cur_set_o = set_q[mshr_idx_i];
    assign cur_way_o = way_q[mshr_idx_i];
    assign cur_state_o = state_q[mshr_idx_i];
    assign cur_hprot_o = hprot_q[mshr_idx_i];
    assign cur_invack_cnt_o = invack_cnt_q[mshr_idx_i];
    assign cur_line_o = line_q[mshr_idx_i];
    assign cur_word_mask_o = word_mask_q[mshr_idx_i];
    assign cur_word_mask_reg_o = word_mask_reg_q[mshr_idx_i];

endmodule

`default_nettype wire

// File: design/mshr_search.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_search (
    input  logic clk,
    input  logic rst,
    input  logic [llc_mshr_pkg::OP_BITS-1:0] op_code_i,
    // incoming request address breakdown
    input  logic [llc_mshr_pkg::TAG_BITS-1:0] req_tag_i,
    input  logic [llc_mshr_pkg::SET_BITS-1:0] req_set_i,
    // per-entry fields from the table
    input  logic [llc_mshr_pkg::TAG_BITS-1:0] tags_i [llc_mshr_pkg::N_MSHR],
    input  logic [llc_mshr_pkg::SET_BITS-1:0] sets_i [llc_mshr_pkg::N_MSHR],
    input  logic [llc_mshr_pkg::STATE_BITS-1:0] states_i [llc_mshr_pkg::N_MSHR],
    // registered result
    output logic [llc_mshr_pkg::MSHR_BITS-1:0] mshr_idx_o,
    output logic mshr_hit_o,
    // same-cycle triggers for the controller's set-conflict flag
    output logic set_conflict_o,
    output logic clr_conflict_o
);

    logic [llc_mshr_pkg::MSHR_BITS-1:0] idx_next;
    logic hit_next;

    always_comb begin
        idx_next = '0;
        hit_next = 1'b0;
        set_conflict_o = 1'b0;
        clr_conflict_o = 1'b0;

        case (op_code_i)
            llc_mshr_pkg::OP_LOOKUP: begin
                // tag and set match on a busy entry
                // later entries overwrite, so highest index wins
                for (int unsigned i = 0; i < llc_mshr_pkg::N_MSHR; i++) begin
                    if (states_i[i] != llc_mshr_pkg::LLC_I &&
                        tags_i[i] == req_tag_i && sets_i[i] == req_set_i) begin
                        hit_next = 1'b1;
                        idx_next = i[llc_mshr_pkg::MSHR_BITS-1:0];
                    end
                end
            end
            llc_mshr_pkg::OP_PEEK_REQ: begin
                // clear unless some busy entry holds the same set
                clr_conflict_o = 1'b1;
                for (int unsigned i = 0; i < llc_mshr_pkg::N_MSHR; i++) begin
                    // highest free entry becomes the next slot
                    if (states_i[i] == llc_mshr_pkg::LLC_I) begin
                        idx_next = i[llc_mshr_pkg::MSHR_BITS-1:0];
                    end
                    if (states_i[i] != llc_mshr_pkg::LLC_I && sets_i[i] == req_set_i) begin
                        set_conflict_o = 1'b1;
                        clr_conflict_o = 1'b0;
                    end
                end
            end
            default: begin
                // idle, index and hit hold in the register below
                hit_next = 1'b0;
            end
        endcase
    end

    // one-cycle result register, frozen while idle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mshr_idx_o <= '0;
            mshr_hit_o <= 1'b0;
        end else if (op_code_i != llc_mshr_pkg::OP_IDLE) begin
            mshr_idx_o <= idx_next;
            mshr_hit_o <= hit_next;
        end
    end

endmodule

`default_nettype wire

// File: design/llc_mshr.sv
`timescale 1ns/1ps
`default_nettype none

module llc_mshr (
    input  logic clk,
    input  logic rst,
    input  logic [llc_mshr_pkg::OP_BITS-1:0] op_code_i,
    // entry write strobes from the controller FSM
    input  logic add_entry_i,
    input  logic upd_tag_i,
    input  logic upd_state_i,
    input  logic upd_line_i,
    input  logic upd_word_mask_i,
    input  logic upd_invack_cnt_i,
    // write values
    input  logic [llc_mshr_pkg::MSG_BITS-1:0] msg_i,
    input  logic [llc_mshr_pkg::REQ_ID_BITS-1:0] req_id_i,
    input  logic [llc_mshr_pkg::TAG_BITS-1:0] tag_i,
    input  logic [llc_mshr_pkg::WAY_BITS-1:0] way_i,
    input  logic [llc_mshr_pkg::STATE_BITS-1:0] state_i,
    input  logic [llc_mshr_pkg::HPROT_BITS-1:0] hprot_i,
    input  logic [llc_mshr_pkg::INVACK_BITS-1:0] invack_cnt_i,
    input  logic [llc_mshr_pkg::LINE_BITS-1:0] line_i,
    input  logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_i,
    input  logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_reg_i,
    // request address breakdown
    input  logic [llc_mshr_pkg::TAG_BITS-1:0] req_tag_i,
    input  logic [llc_mshr_pkg::SET_BITS-1:0] req_set_i,
    // search results
    output logic mshr_hit_o,
    output logic [llc_mshr_pkg::MSHR_BITS-1:0] mshr_idx_o,
    output logic set_conflict_o,
    output logic clr_conflict_o,
    // current entry
    output logic [llc_mshr_pkg::MSG_BITS-1:0] cur_msg_o,
    output logic [llc_mshr_pkg::REQ_ID_BITS-1:0] cur_req_id_o,
    output logic [llc_mshr_pkg::TAG_BITS-1:0] cur_tag_o,
    output logic [llc_mshr_pkg::SET_BITS-1:0] cur_set_o,
    output logic [llc_mshr_pkg::WAY_BITS-1:0] cur_way_o,
    output logic [llc_mshr_pkg::STATE_BITS-1:0] cur_state_o,
    output logic [llc_mshr_pkg::HPROT_BITS-1:0] cur_hprot_o,
    output logic [llc_mshr_pkg::INVACK_BITS-1:0] cur_invack_cnt_o,
    output logic [llc_mshr_pkg::LINE_BITS-1:0] cur_line_o,
    output logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_o,
    output logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_reg_o
);

    // table fields seen by the search
    logic [llc_mshr_pkg::TAG_BITS-1:0] tags [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::SET_BITS-1:0] sets [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::STATE_BITS-1:0] states [llc_mshr_pkg::N_MSHR];

    // write bundle toward the table
    mshr_write_if wr_if ();

    assign wr_if.add_entry = add_entry_i;
    assign wr_if.upd_tag = upd_tag_i;
    assign wr_if.upd_state = upd_state_i;
    assign wr_if.upd_line = upd_line_i;
    assign wr_if.upd_word_mask = upd_word_mask_i;
    assign wr_if.upd_invack_cnt = upd_invack_cnt_i;
    assign wr_if.msg = msg_i;
    assign wr_if.req_id = req_id_i;
    assign wr_if.tag = tag_i;
    assign wr_if.way = way_i;
    assign wr_if.state = state_i;
    assign wr_if.hprot = hprot_i;
    assign wr_if.invack_cnt = invack_cnt_i;
    assign wr_if.line = line_i;
    assign wr_if.word_mask = word_mask_i;
    assign wr_if.word_mask_reg = word_mask_reg_i;
    // entry set taken from the request, same as the search
    assign wr_if.set = req_set_i;

    // storage, written at the registered index
    mshr_entry_table i_mshr_entry_table (
        .clk                 (clk),
        .rst                 (rst),
        .wr_if               (wr_if.tbl),
        .mshr_idx_i          (mshr_idx_o),
        .tags_o              (tags),
        .sets_o              (sets),
        .states_o            (states),
        .cur_msg_o           (cur_msg_o),
        .cur_req_id_o        (cur_req_id_o),
        .cur_tag_o           (cur_tag_o),
        .cur_set_o           (cur_set_o),
        .cur_way_o           (cur_way_o),
        .cur_state_o         (cur_state_o),
        .cur_hprot_o         (cur_hprot_o),
        .cur_invack_cnt_o    (cur_invack_cnt_o),
        .cur_line_o          (cur_line_o),
        .cur_word_mask_o     (cur_word_mask_o),
        .cur_word_mask_reg_o (cur_word_mask_reg_o)
    );

    // lookup and peek-request, owns the index register
    mshr_search i_mshr_search (
        .clk            (clk),
        .rst            (rst),
        .op_code_i      (op_code_i),
        .req_tag_i      (req_tag_i),
        .req_set_i      (req_set_i),
        .tags_i         (tags),
        .sets_i         (sets),
        .states_i       (states),
        .mshr_idx_o     (mshr_idx_o),
        .mshr_hit_o     (mshr_hit_o),
        .set_conflict_o (set_conflict_o),
        .clr_conflict_o (clr_conflict_o)
    );

endmodule

`default_nettype wire

// File: tests/llc_mshr_properties.sv
`timescale 1ns/1ps
`default_nettype none

module llc_mshr_properties (
    input  logic clk,
    input  logic rst,
    input  logic [llc_mshr_pkg::OP_BITS-1:0] op_code_i,
    input  logic set_conflict_i,
    input  logic clr_conflict_i,
    input  logic mshr_hit_i
);

    // failed assertion count, read by the testbench at the end
    int unsigned fail_count = 0;

    // triggers are exclusive
    a_trig_excl: assert property (@(posedge clk) disable iff (!rst)
        !(set_conflict_i && clr_conflict_i))
        else begin
            fail_count++;
            $error("set and clear conflict triggers both high");
        end

    // triggers only during a peek-request
    a_trig_peek_only: assert property (@(posedge clk) disable iff (!rst)
        (op_code_i != llc_mshr_pkg::OP_PEEK_REQ) |-> !set_conflict_i && !clr_conflict_i)
        else begin
            fail_count++;
            $error("conflict trigger outside a peek-request");
        end

    // a peek-request never reports a hit
    a_peek_no_hit: assert property (@(posedge clk) disable iff (!rst)
        (op_code_i == llc_mshr_pkg::OP_PEEK_REQ) |=> !mshr_hit_i)
        else begin
            fail_count++;
            $error("hit flag set after a peek-request");
        end

endmodule

bind llc_mshr llc_mshr_properties i_llc_mshr_properties (
    .clk            (clk),
    .rst            (rst),
    .op_code_i      (op_code_i),
    .set_conflict_i (set_conflict_o),
    .clr_conflict_i (clr_conflict_o),
    .mshr_hit_i     (mshr_hit_o)
);

`default_nettype wire

// File: tests/llc_mshr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module llc_mshr_tb;

    // raw text lines allowed before the read loop gives up
    localparam int MAX_LINES = 64;
    // data lines expected in the vector file
    localparam int NUM_VECTORS = 22;

    // side fields, fixed values written on every add
    localparam logic [llc_mshr_pkg::MSG_BITS-1:0] SIDE_MSG = 5'h11;
    localparam logic [llc_mshr_pkg::REQ_ID_BITS-1:0] SIDE_REQ_ID = 4'h6;
    localparam logic [llc_mshr_pkg::WAY_BITS-1:0] SIDE_WAY = 4'h9;
    localparam logic [llc_mshr_pkg::HPROT_BITS-1:0] SIDE_HPROT = 2'h1;
    localparam logic [llc_mshr_pkg::INVACK_BITS-1:0] SIDE_INVACK = 4'h2;
    localparam logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] SIDE_WORD_MASK = 4'hf;
    localparam logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] SIDE_WORD_MASK_REG = 4'h5;

    logic clk;
    logic rst;
    logic [llc_mshr_pkg::OP_BITS-1:0] op_code_i;
    logic add_entry_i;
    logic upd_tag_i;
    logic upd_state_i;
    logic upd_line_i;
    logic upd_word_mask_i;
    logic upd_invack_cnt_i;
    logic [llc_mshr_pkg::MSG_BITS-1:0] msg_i;
    logic [llc_mshr_pkg::REQ_ID_BITS-1:0] req_id_i;
    logic [llc_mshr_pkg::TAG_BITS-1:0] tag_i;
    logic [llc_mshr_pkg::WAY_BITS-1:0] way_i;
    logic [llc_mshr_pkg::STATE_BITS-1:0] state_i;
    logic [llc_mshr_pkg::HPROT_BITS-1:0] hprot_i;
    logic [llc_mshr_pkg::INVACK_BITS-1:0] invack_cnt_i;
    logic [llc_mshr_pkg::LINE_BITS-1:0] line_i;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_i;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] word_mask_reg_i;
    logic [llc_mshr_pkg::TAG_BITS-1:0] req_tag_i;
    logic [llc_mshr_pkg::SET_BITS-1:0] req_set_i;
    logic mshr_hit_o;
    logic [llc_mshr_pkg::MSHR_BITS-1:0] mshr_idx_o;
    logic set_conflict_o;
    logic clr_conflict_o;
    logic [llc_mshr_pkg::MSG_BITS-1:0] cur_msg_o;
    logic [llc_mshr_pkg::REQ_ID_BITS-1:0] cur_req_id_o;
    logic [llc_mshr_pkg::TAG_BITS-1:0] cur_tag_o;
    logic [llc_mshr_pkg::SET_BITS-1:0] cur_set_o;
    logic [llc_mshr_pkg::WAY_BITS-1:0] cur_way_o;
    logic [llc_mshr_pkg::STATE_BITS-1:0] cur_state_o;
    logic [llc_mshr_pkg::HPROT_BITS-1:0] cur_hprot_o;
    logic [llc_mshr_pkg::INVACK_BITS-1:0] cur_invack_cnt_o;
    logic [llc_mshr_pkg::LINE_BITS-1:0] cur_line_o;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_o;
    logic [llc_mshr_pkg::WORDS_PER_LINE-1:0] cur_word_mask_reg_o;

    // one parsed vector, stimulus then expected outputs
    logic [llc_mshr_pkg::OP_BITS-1:0] v_op;
    logic v_add;
    logic v_upd_tag;
    logic v_upd_state;
    logic v_upd_line;
    logic [llc_mshr_pkg::TAG_BITS-1:0] v_tag;
    logic [llc_mshr_pkg::STATE_BITS-1:0] v_state;
    logic [llc_mshr_pkg::LINE_BITS-1:0] v_line;
    logic [llc_mshr_pkg::TAG_BITS-1:0] v_req_tag;
    logic [llc_mshr_pkg::SET_BITS-1:0] v_req_set;
    logic exp_set_cf;
    logic exp_clr_cf;
    logic exp_hit;
    logic [llc_mshr_pkg::MSHR_BITS-1:0] exp_idx;
    logic [llc_mshr_pkg::STATE_BITS-1:0] exp_state;
    logic [llc_mshr_pkg::TAG_BITS-1:0] exp_tag;
    logic [llc_mshr_pkg::LINE_BITS-1:0] exp_line;

    // entries added so far and the request set each one took
    logic entry_added [llc_mshr_pkg::N_MSHR];
    logic [llc_mshr_pkg::SET_BITS-1:0] entry_set [llc_mshr_pkg::N_MSHR];

    string text;
    int fd;
    int rc;
    int line_count;
    int vec_count;
    logic at_eof;

    llc_mshr i_llc_mshr (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("ERROR: %s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s at vector %0d: expected 0x%0h, actual 0x%0h",
                     name, vec_count, expected, actual);
            stop_with_failure("output differs from the expected value");
        end
    endtask

    // stimulus of the current vector onto the DUT pins
    task automatic drive_vector();
        op_code_i = v_op;
        add_entry_i = v_add;
        upd_tag_i = v_upd_tag;
        upd_state_i = v_upd_state;
        upd_line_i = v_upd_line;
        tag_i = v_tag;
        state_i = v_state;
        line_i = v_line;
        req_tag_i = v_req_tag;
        req_set_i = v_req_set;
    endtask

    // fields outside the vector columns
    // an added entry holds the side values, an untouched one is still zero
    task automatic check_side_fields();
        logic added;
        added = entry_added[exp_idx];
        compare("cur_msg_o", added ? SIDE_MSG : '0, cur_msg_o);
        compare("cur_req_id_o", added ? SIDE_REQ_ID : '0, cur_req_id_o);
        compare("cur_set_o", added ? entry_set[exp_idx] : '0, cur_set_o);
        compare("cur_way_o", added ? SIDE_WAY : '0, cur_way_o);
        compare("cur_hprot_o", added ? SIDE_HPROT : '0, cur_hprot_o);
        compare("cur_invack_cnt_o", added ? SIDE_INVACK : '0, cur_invack_cnt_o);
        compare("cur_word_mask_o", added ? SIDE_WORD_MASK : '0, cur_word_mask_o);
        compare("cur_word_mask_reg_o", added ? SIDE_WORD_MASK_REG : '0,
                cur_word_mask_reg_o);
    endtask

    task automatic check_outputs();
        compare("set_conflict_o", exp_set_cf, set_conflict_o);
        compare("clr_conflict_o", exp_clr_cf, clr_conflict_o);
        compare("mshr_hit_o", exp_hit, mshr_hit_o);
        compare("mshr_idx_o", exp_idx, mshr_idx_o);
        compare("cur_state_o", exp_state, cur_state_o);
        compare("cur_tag_o", exp_tag, cur_tag_o);
        compare("cur_line_o", exp_line, cur_line_o);
        check_side_fields();
        if (i_llc_mshr.i_llc_mshr_properties.fail_count != 0) begin
            stop_with_failure("a concurrent assertion on the search outputs failed");
        end
    endtask

    initial begin
        rst = 1'b0;
        op_code_i = llc_mshr_pkg::OP_IDLE;
        add_entry_i = 1'b0;
        upd_tag_i = 1'b0;
        upd_state_i = 1'b0;
        upd_line_i = 1'b0;
        upd_word_mask_i = 1'b0;
        upd_invack_cnt_i = 1'b0;
        msg_i = SIDE_MSG;
        req_id_i = SIDE_REQ_ID;
        tag_i = '0;
        way_i = SIDE_WAY;
        state_i = '0;
        hprot_i = SIDE_HPROT;
        invack_cnt_i = SIDE_INVACK;
        line_i = '0;
        word_mask_i = SIDE_WORD_MASK;
        word_mask_reg_i = SIDE_WORD_MASK_REG;
        req_tag_i = '0;
        req_set_i = '0;
        line_count = 0;
        vec_count = 0;
        at_eof = 1'b0;
        for (int k = 0; k < llc_mshr_pkg::N_MSHR; k++) begin
            entry_added[k] = 1'b0;
            entry_set[k] = '0;
        end

        fd = $fopen("tests/llc_mshr_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the vector file tests/llc_mshr_vectors.txt");
        end

        // two rising edges in reset
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        // one data line per cycle, comment lines skipped
        while (!at_eof) begin
            if (line_count >= MAX_LINES) begin
                stop_with_failure("vector file has more lines than the read limit");
            end else if ($fgets(text, fd) == 0) begin
                at_eof = 1'b1;
            end else begin
                line_count++;
                if (text.len() > 1 && text.getc(0) != "#") begin
                    rc = $sscanf(text,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_op, v_add, v_upd_tag, v_upd_state, v_upd_line, v_tag, v_state,
                        v_line, v_req_tag, v_req_set, exp_set_cf, exp_clr_cf, exp_hit,
                        exp_idx, exp_state, exp_tag, exp_line);
                    if (rc != 17) begin
                        stop_with_failure($sformatf(
                            "vector file line %0d holds %0d fields instead of 17",
                            line_count, rc));
                    end else begin
                        vec_count++;
                        drive_vector();
                        // sample just before the edge that ends the cycle
                        #8;
                        check_outputs();
                        // an add lands at the index registered in this cycle
                        if (v_add) begin
                            entry_added[exp_idx] = 1'b1;
                            entry_set[exp_idx] = v_req_set;
                        end
                        @(posedge clk);
                        #1;
                    end
                end
            end
        end
        $fclose(fd);

        if (vec_count != NUM_VECTORS) begin
            stop_with_failure($sformatf("vector file is short, read %0d of %0d vectors",
                                        vec_count, NUM_VECTORS));
        end else if (i_llc_mshr.i_llc_mshr_properties.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("a concurrent assertion on the search outputs failed");
        end
    end

endmodule

`default_nettype wire

// File: tests/llc_mshr_vectors.txt
# stimulus: op add upd_tag upd_state upd_line tag state line req_tag req_set
# expected before the closing edge: set_cf clr_cf hit idx cur_state cur_tag cur_line
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 0 0 0000 00000000
2 0 0 0 0 0000 0 00000000 0000 10  0 1 0 0 0 0000 00000000
0 1 0 0 0 beef 3 11112222 0000 10  0 0 0 3 0 0000 00000000
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 3 3 beef 11112222
1 0 0 0 0 0000 0 00000000 beef 10  0 0 0 3 3 beef 11112222
1 0 0 0 0 0000 0 00000000 dead 10  0 0 1 3 3 beef 11112222
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 0 0 0000 00000000
2 0 0 0 0 0000 0 00000000 0000 10  1 0 0 0 0 0000 00000000
0 1 0 0 0 1234 2 0000abcd 0000 20  0 0 0 2 0 0000 00000000
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 2 2 1234 0000abcd
0 0 0 0 1 ffff 7 00005555 0000 00  0 0 0 2 2 1234 0000abcd
0 0 0 1 0 ffff 4 00009999 0000 00  0 0 0 2 2 1234 00005555
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 2 4 1234 00005555
1 0 0 0 0 0000 0 00000000 beef 10  0 0 0 2 4 1234 00005555
0 0 0 1 0 0000 0 00000000 0000 00  0 0 1 3 3 beef 11112222
0 0 0 0 0 0000 0 00000000 0000 00  0 0 1 3 0 beef 11112222
1 0 0 0 0 0000 0 00000000 beef 10  0 0 1 3 0 beef 11112222
2 0 0 0 0 0000 0 00000000 0000 10  0 1 0 0 0 0000 00000000
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 3 0 beef 11112222
1 0 0 0 0 0000 0 00000000 1234 20  0 0 0 3 0 beef 11112222
2 0 0 0 0 0000 0 00000000 0000 20  1 0 1 2 4 1234 00005555
0 0 0 0 0 0000 0 00000000 0000 00  0 0 0 3 0 beef 11112222

// File: sim.f
design/llc_mshr_pkg.sv
design/mshr_write_if.sv
design/mshr_entry_table.sv
design/mshr_search.sv
design/llc_mshr.sv
tests/llc_mshr_properties.sv
tests/llc_mshr_tb.sv
